// File: Bender.yml
package:
  name: sprite_engine

sources:
  - verilog/spriteFormatPkg.sv
  - verilog/busPkg.sv
  - verilog/spriteJobIf.sv
  - verilog/attributeRam.sv
  - verilog/spriteScanner.sv
  - verilog/tileFetcher.sv
  - verilog/lineBuffers.sv
  - verilog/spriteEngine.sv
  - target: test
    files:
      - test/spriteEngine_assertions.sv
      - test/spriteEngineTb.sv

// File: test/spriteEngineTb.sv
// Sprite engine testbench
// Graphics ROM model, line reference model and the pixel and CPU checks
`timescale 1ns/1ps

module spriteEngineTb;

	localparam int spriteCount = 128;
	localparam int scanTimeout = 50000; // Cycles for one line scan

	typedef spriteFormatPkg::pixelT [255:0] linePixelsT; // One screen line

	logic                     clk;
	logic                     rst;
	logic                     cpuSel;
	logic                     cpuWrite;
	busPkg::cpuAddrT          cpuAddr;
	busPkg::byteT             cpuWrData;
	busPkg::byteT             cpuRdData;
	logic                     lineStart;
	spriteFormatPkg::lineT    lineY;
	logic                     scanBusy;
	logic                     pixelEn;
	spriteFormatPkg::screenXT pixelX;
	spriteFormatPkg::pixelT   pixelOut;
	logic                     romReq;
	busPkg::romAddrT          romAddr;
	logic                     romRdy;
	busPkg::romWordT          romData;

	busPkg::byteT attrMem [spriteCount*4]; // Copy of what the CPU wrote
	integer       seed = 32'h6d86_076d;

	spriteEngine #(.spriteCount(spriteCount)) i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// Graphics ROM model
	// ------------------------------------------------------------------------
	function automatic busPkg::romWordT romWord(input busPkg::romAddrT addr);
		busPkg::romWordT w;
		int              i;
		w = 16'(addr * 17'h0B5D3) ^ {addr[7:0], addr[16:9]};
		for (i = 0; i < 4; i++) begin
			if (w[4*i +: 4] < 4'd4) begin
				w[4*i +: 4] = 4'h0; // Some see-through pixels
			end
		end
		return w;
	endfunction

	initial begin
		busPkg::romAddrT reqAddr;
		int              latency;
		forever begin
			@(posedge clk);
			if (romReq) begin
				reqAddr = romAddr;
				latency = $random(seed) & 7;   // 0..7 cycles
				repeat (latency) @(posedge clk);
				romRdy  <= 1'b1;
				romData <= romWord(reqAddr);
				@(posedge clk);
				romRdy  <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------------
	function automatic linePixelsT renderLine(input spriteFormatPkg::lineT y);
		linePixelsT               pix;
		spriteFormatPkg::lineT    sum;
		busPkg::byteT             posY, attr, tileLo, posX;
		spriteFormatPkg::tileT    tile;
		spriteFormatPkg::rowT     row;
		spriteFormatPkg::columnT  col;
		busPkg::romWordT          word;
		spriteFormatPkg::colorT   color;
		spriteFormatPkg::screenXT x;
		int                       s, w, p, c;
		pix = '0;
		for (s = 0; s < spriteCount; s++) begin   // Later sprites drawn on top
			posY   = attrMem[4*s + spriteFormatPkg::offsetPosY];
			attr   = attrMem[4*s + spriteFormatPkg::offsetAttr];
			tileLo = attrMem[4*s + spriteFormatPkg::offsetTileLo];
			posX   = attrMem[4*s + spriteFormatPkg::offsetPosX];
			sum    = y + posY;
			if (sum[7:5] == 3'b111 && (sum[4] || attr[7])) begin
				row  = sum[3:0];
				tile = {attr[2:0], tileLo};
				if (attr[7]) begin
					tile[0] = sum[4];               // Upper or lower tile
				end
				for (w = 0; w < 4; w++) begin
					col  = w[1:0];
					word = romWord({tile, col, row});
					for (p = 0; p < spriteFormatPkg::pixelsPerWord; p++) begin
						c     = 4*w + p;
						color = word[15 - 4*p -: 4];
						if (color != 4'h0) begin
							x = attr[6] ? posX + 8'(15 - c) : posX + 8'(c); // Wraps
							pix[x] = {attr[5:3], color};
						end
					end
				end
			end
		end
		return pix;
	endfunction

	// ------------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------------
	task automatic abortRun();
		$display("test failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkByte(input string name, input busPkg::byteT got,
	                         input busPkg::byteT exp);
		if (got !== exp) begin
			$display("Error: %s = %h, expected %h", name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkPixel(input string name, input spriteFormatPkg::pixelT got,
	                          input spriteFormatPkg::pixelT exp);
		if (got !== exp) begin
			$display("Error: %s = %h, expected %h", name, got, exp);
			abortRun();
		end
	endtask

	always @(negedge clk) begin
		if (i_dut.i_assertions.anyFail) begin
			$display("A protocol assertion fired");
			abortRun();
		end
	end

	// ------------------------------------------------------------------------
	// Bus tasks
	// ------------------------------------------------------------------------
	task automatic cpuWriteByte(input busPkg::cpuAddrT addr, input busPkg::byteT data);
		@(posedge clk);
		cpuSel    <= 1'b1;
		cpuWrite  <= 1'b1;
		cpuAddr   <= addr;
		cpuWrData <= data;
		@(posedge clk);
		cpuSel    <= 1'b0;
		cpuWrite  <= 1'b0;
		attrMem[addr] = data;
	endtask

	task automatic cpuReadByte(input busPkg::cpuAddrT addr);
		@(posedge clk);
		cpuSel   <= 1'b1;
		cpuWrite <= 1'b0;
		cpuAddr  <= addr;
		@(posedge clk);
		cpuSel   <= 1'b0;
		@(negedge clk);
		checkByte("cpuRdData", cpuRdData, attrMem[addr]);
		@(negedge clk);
		checkByte("cpuRdData", cpuRdData, busPkg::idleReadValue); // Bus idle again
	endtask

	task automatic placeSprite(input int idx, input busPkg::byteT posY,
	                           input busPkg::byteT attr, input busPkg::byteT tileLo,
	                           input busPkg::byteT posX);
		busPkg::cpuAddrT base;
		base = 9'(idx * 4);
		cpuWriteByte(base + spriteFormatPkg::offsetPosY, posY);
		cpuWriteByte(base + spriteFormatPkg::offsetAttr, attr);
		cpuWriteByte(base + spriteFormatPkg::offsetTileLo, tileLo);
		cpuWriteByte(base + spriteFormatPkg::offsetPosX, posX);
	endtask

	task automatic waitScanIdle();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (scanBusy) begin
			@(negedge clk);
			cycles++;
			if (cycles > scanTimeout) begin
				$display("Timeout: scanBusy did not fall");
				abortRun();
			end
		end
	endtask

	task automatic pulseLineStart(input spriteFormatPkg::lineT y);
		@(posedge clk);
		lineStart <= 1'b1;
		lineY     <= y;
		@(posedge clk);
		lineStart <= 1'b0;
	endtask

	// Reads all 256 display pixels, which also clears them
	task automatic scanOutLine(input bit check, input linePixelsT expected);
		int x;
		for (x = 0; x < 256; x++) begin
			@(posedge clk);
			pixelEn <= 1'b1;
			pixelX  <= 8'(x);
			@(posedge clk);
			pixelEn <= 1'b0;
			@(negedge clk);
			if (check) begin
				checkPixel($sformatf("pixelOut[%0d]", x), pixelOut, expected[x]);
			end
		end
	endtask

	task automatic runLine(input spriteFormatPkg::lineT y);
		linePixelsT expected;
		waitScanIdle();
		pulseLineStart(y);
		scanOutLine(1'b0, '0);     // Flush the stale display buffer
		waitScanIdle();
		pulseLineStart(y);         // Swap puts the drawn line on display
		expected = renderLine(y);
		scanOutLine(1'b1, expected);
		scanOutLine(1'b1, '0);     // Second read sees cleared entries
		waitScanIdle();
	endtask

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------
	initial begin
		int           a, trial;
		busPkg::byteT data;
		rst       = 1'b1;
		cpuSel    = 1'b0;
		cpuWrite  = 1'b0;
		cpuAddr   = '0;
		cpuWrData = '0;
		lineStart = 1'b0;
		lineY     = '0;
		pixelEn   = 1'b0;
		pixelX    = '0;
		romRdy    = 1'b0;
		romData   = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		// CPU write and read back of every byte
		for (a = 0; a < spriteCount*4; a++) begin
			cpuWriteByte(9'(a), 8'($random(seed)));
		end
		for (a = 0; a < spriteCount*4; a++) begin
			cpuReadByte(9'(a));
		end

		// Warm-up with every sprite off line 0
		for (a = 0; a < spriteCount; a++) begin
			cpuWriteByte(9'(4*a), 8'h00);
		end
		repeat (2) begin
			waitScanIdle();
			pulseLineStart(8'h00);
			scanOutLine(1'b0, '0);
		end
		waitScanIdle();

		// Single plain sprite, hit and miss lines
		placeSprite(5, 8'hB3, 8'h29, 8'h47, 8'h30);
		runLine(8'h40);
		runLine(8'h20);
		runLine(8'h4C);    // Last row

		// Mirroring, double height and wrap at x = 255
		placeSprite(9, 8'hA8, 8'h9A, 8'h64, 8'h60);
		placeSprite(12, 8'hB2, 8'hF0, 8'h21, 8'hFC);
		placeSprite(20, 8'hB5, 8'h67, 8'hFE, 8'hF8);
		placeSprite(30, 8'hB0, 8'h15, 8'h88, 8'hFA);
		runLine(8'h40);
		runLine(8'h48);    // Other half of the tall sprites

		// Random overlapping sprites
		for (trial = 0; trial < 4; trial++) begin
			for (a = 0; a < spriteCount*4; a++) begin
				data = 8'($random(seed));
				if (a % 8 == 7) begin
					data = 8'h70 + {3'b000, data[4:0]}; // Crowd these together
				end
				cpuWriteByte(9'(a), data);
			end
			runLine(8'($random(seed)));
		end

		if (!i_dut.i_assertions.anyFail) begin
			$display("test passed");
			$finish;
		end else begin
			abortRun();
		end
	end

endmodule

// File: test/spriteEngine_assertions.sv
// Sprite engine protocol assertions
// ROM handshake, line start rule and the idle value of the CPU read bus
`timescale 1ns/1ps

module spriteEngine_assertions (
	input logic         clk,
	input logic         rst,
	input logic         cpuSel,
	input logic         cpuWrite,
	input busPkg::byteT cpuRdData,
	input logic         lineStart,
	input logic         scanBusy,
	input logic         romReq,
	input logic         romRdy
);

	logic romPending;             // Request sent, no romRdy yet
	logic romFail     = 1'b0;
	logic lineFail    = 1'b0;
	logic idleFail    = 1'b0;
	logic anyFail;                // Watched by the testbench

	assign anyFail = romFail | lineFail | idleFail;

	always_ff @(posedge clk) begin
		if (rst) begin
			romPending <= 1'b0;
		end else if (romReq) begin
			romPending <= 1'b1;
		end else if (romRdy) begin
			romPending <= 1'b0;
		end
	end

	// ------------------------------------------------------------------------
	// Rules
	// ------------------------------------------------------------------------
	romSingle: assert property (@(posedge clk) disable iff (rst) romReq |-> !romPending)
		else begin
			$error("romReq while a ROM request is outstanding");
			romFail = 1'b1;
		end

	lineIdle: assert property (@(posedge clk) disable iff (rst) lineStart |-> !scanBusy)
		else begin
			$error("lineStart while scanBusy is high");
			lineFail = 1'b1;
		end

	readIdle: assert property (@(posedge clk) disable iff (rst)
		!(cpuSel && !cpuWrite) |=> (cpuRdData == busPkg::idleReadValue))
		else begin
			$error("cpuRdData not at its idle value after a cycle without a read");
			idleFail = 1'b1;
		end

endmodule

bind spriteEngine spriteEngine_assertions i_assertions (
	.clk       (clk),
	.rst       (rst),
	.cpuSel    (cpuSel),
	.cpuWrite  (cpuWrite),
	.cpuRdData (cpuRdData),
	.lineStart (lineStart),
	.scanBusy  (scanBusy),
	.romReq    (romReq),
	.romRdy    (romRdy)
);

// File: verilog.f
verilog/spriteFormatPkg.sv
verilog/busPkg.sv
verilog/spriteJobIf.sv
verilog/attributeRam.sv
verilog/spriteScanner.sv
verilog/tileFetcher.sv
verilog/lineBuffers.sv
verilog/spriteEngine.sv
test/spriteEngine_assertions.sv
test/spriteEngineTb.sv

// File: verilog/attributeRam.sv
// Sprite attribute RAM
// 4 bytes per sprite, one RAM port shared by the CPU and the line scan.
// The CPU always wins; a scan read is granted one cycle later or dropped.
`timescale 1ns/1ps

module attributeRam #(
	parameter int spriteCount = 128
) (
	input  logic                      clk,
	input  logic                      cpuSel,
	input  logic                      cpuWrite,
	input  busPkg::cpuAddrT           cpuAddr,
	input  busPkg::byteT              cpuWrData,
	input  logic                      scanRead,
	input  busPkg::cpuAddrT           scanAddr,
	output busPkg::byteT              cpuRdData,
	output spriteFormatPkg::attrByteT scanData,
	output logic                      scanGrant
);

	localparam int depth = spriteCount * 4;

	busPkg::byteT    mem [depth];  // Sprite records
	busPkg::cpuAddrT ramAddr;      // Address of the single port

	// ------------------------------------------------------------------------
	// Port arbitration
	// ------------------------------------------------------------------------
	assign ramAddr = cpuSel ? cpuAddr : scanAddr; // CPU has priority

	always_ff @(posedge clk) begin
		if (cpuSel && cpuWrite) begin
			mem[ramAddr] <= cpuWrData;     // Takes effect at this edge
		end

		// Scan data only meaningful together with the grant
		scanData  <= mem[ramAddr];
		scanGrant <= scanRead && !cpuSel; // Lost to the CPU, scanner retries

		// Registered CPU read, idle value otherwise
		if (cpuSel && !cpuWrite) begin
			cpuRdData <= mem[ramAddr];
		end else begin
			cpuRdData <= busPkg::idleReadValue;
		end
	end

endmodule

// File: verilog/busPkg.sv
// Bus definitions
// Widths of the CPU attribute port and the graphics ROM port
package busPkg;

	typedef logic [8:0]  cpuAddrT;  // 512 attribute bytes
	typedef logic [7:0]  byteT;

	// ROM address is {tile, column, row}
	typedef logic [16:0] romAddrT;
	typedef logic [15:0] romWordT;  // Four 4-bit pixels, leftmost in 15..12

	// Value seen on the CPU read bus when nothing is read
	localparam byteT idleReadValue = 8'hFF;

endpackage

// File: verilog/lineBuffers.sv
// Sprite line buffers
// Ping-pong pair of 256-pixel buffers; the fetcher draws into one while
// the display reads the other, clearing each entry as it is read
`timescale 1ns/1ps

module lineBuffers (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     lineStart,
	input  logic                     drawWrite,
	input  spriteFormatPkg::screenXT drawX,
	input  spriteFormatPkg::pixelT   drawPixel,
	input  logic                     pixelEn,
	input  spriteFormatPkg::screenXT pixelX,
	output spriteFormatPkg::pixelT   pixelOut
);

	logic                   drawSel;    // Buffer being drawn, other one shown
	spriteFormatPkg::pixelT bankRd [2]; // Display-side read of each buffer

	// ------------------------------------------------------------------------
	// Buffer swap
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			drawSel <= 1'b0;
		end else if (lineStart) begin
			drawSel <= !drawSel;
		end
	end

	// ------------------------------------------------------------------------
	// The two buffers
	// ------------------------------------------------------------------------
	for (genvar b = 0; b < 2; b++) begin : gBank
		spriteFormatPkg::pixelT ram [256];

		always_ff @(posedge clk) begin
			if (drawSel == 1'(b)) begin
				if (drawWrite) begin
					ram[drawX] <= drawPixel;   // Later sprite overwrites
				end
			end else if (pixelEn) begin
				ram[pixelX] <= '0;             // Clear behind the display
			end
		end

		assign bankRd[b] = ram[pixelX];
	end

	// Display read, one cycle after pixelEn
	always_ff @(posedge clk) begin
		if (pixelEn) begin
			pixelOut <= bankRd[!drawSel];
		end
	end

endmodule

// File: verilog/spriteEngine.sv
// Sprite engine top level
// CPU attribute RAM, line scanner, ROM tile fetcher and line buffers
`timescale 1ns/1ps

module spriteEngine #(
	parameter int spriteCount = 128
) (
	input  logic                     clk,
	input  logic                     rst,
	// CPU port
	input  logic                     cpuSel,
	input  logic                     cpuWrite,
	input  busPkg::cpuAddrT          cpuAddr,
	input  busPkg::byteT             cpuWrData,
	output busPkg::byteT             cpuRdData,
	// Line control
	input  logic                     lineStart,
	input  spriteFormatPkg::lineT    lineY,
	output logic                     scanBusy,
	// Display port
	input  logic                     pixelEn,
	input  spriteFormatPkg::screenXT pixelX,
	output spriteFormatPkg::pixelT   pixelOut,
	// Graphics ROM port
	output logic                     romReq,
	output busPkg::romAddrT          romAddr,
	input  logic                     romRdy,
	input  busPkg::romWordT          romData
);

	logic                      scanRead;
	busPkg::cpuAddrT           scanAddr;
	spriteFormatPkg::attrByteT scanData;
	logic                      scanGrant;
	logic                      drawWrite;
	spriteFormatPkg::screenXT  drawX;
	spriteFormatPkg::pixelT    drawPixel;

	spriteJobIf jobBus ();  // Scanner to fetcher

	attributeRam #(.spriteCount(spriteCount)) i_attributeRam (
		.clk       (clk),
		.cpuSel    (cpuSel),
		.cpuWrite  (cpuWrite),
		.cpuAddr   (cpuAddr),
		.cpuWrData (cpuWrData),
		.scanRead  (scanRead),
		.scanAddr  (scanAddr),
		.cpuRdData (cpuRdData),
		.scanData  (scanData),
		.scanGrant (scanGrant)
	);

	spriteScanner #(.spriteCount(spriteCount)) i_spriteScanner (
		.clk       (clk),
		.rst       (rst),
		.lineStart (lineStart),
		.lineY     (lineY),
		.scanData  (scanData),
		.scanGrant (scanGrant),
		.scanRead  (scanRead),
		.scanAddr  (scanAddr),
		.scanBusy  (scanBusy),
		.job       (jobBus.scanner)
	);

	tileFetcher i_tileFetcher (
		.clk       (clk),
		.rst       (rst),
		.romRdy    (romRdy),
		.romData   (romData),
		.romReq    (romReq),
		.romAddr   (romAddr),
		.drawWrite (drawWrite),
		.drawX     (drawX),
		.drawPixel (drawPixel),
		.job       (jobBus.fetcher)
	);

	lineBuffers i_lineBuffers (
		.clk       (clk),
		.rst       (rst),
		.lineStart (lineStart),
		.drawWrite (drawWrite),
		.drawX     (drawX),
		.drawPixel (drawPixel),
		.pixelEn   (pixelEn),
		.pixelX    (pixelX),
		.pixelOut  (pixelOut)
	);

endmodule

// File: verilog/spriteFormatPkg.sv
// Sprite format definitions
// Attribute record layout, sprite geometry and the pixel types shared by
// the scanner, the fetcher and the line buffers
package spriteFormatPkg;

	typedef logic [7:0] attrByteT;   // One byte of a sprite record

	// ------------------------------------------------------------------------
	// Byte offsets inside a 4-byte sprite record
	// ------------------------------------------------------------------------
	localparam logic [1:0] offsetPosY   = 2'd0; // Vertical position
	localparam logic [1:0] offsetAttr   = 2'd1; // dblH, flipX, palette, tile hi
	localparam logic [1:0] offsetTileLo = 2'd2; // Tile number bits 7..0
	localparam logic [1:0] offsetPosX   = 2'd3; // Horizontal position

	// Attribute byte:
	//   bit 7     double height
	//   bit 6     flipX
	//   bits 5..3 palette
	//   bits 2..0 tile number bits 10..8

	typedef logic [10:0] tileT;      // Tile number
	typedef logic [3:0]  rowT;       // Row inside a tile
	typedef logic [1:0]  columnT;    // 4-pixel column word index
	typedef logic [2:0]  paletteT;
	typedef logic [3:0]  colorT;     // 0 is transparent
	typedef logic [6:0]  pixelT;     // {palette, color}
	typedef logic [7:0]  screenXT;
	typedef logic [7:0]  lineT;

	// ------------------------------------------------------------------------
	// Geometry
	// ------------------------------------------------------------------------
	localparam int spriteWidth   = 16;
	localparam int pixelsPerWord = 4; // One nibble per pixel in a ROM word

endpackage

// File: verilog/spriteJobIf.sv
// Sprite job link
// Carries one hit sprite from the scanner to the tile fetcher
`timescale 1ns/1ps

interface spriteJobIf;

	logic        valid;   // One-cycle pulse, only while busy is low
	logic [10:0] tile;    // Tile number, lsb already fixed for double height
	logic [3:0]  row;     // Row inside the tile
	logic [2:0]  palette;
	logic        flipX;
	logic [7:0]  posX;    // Left edge on screen
	logic        busy;    // Fetcher working, high from the cycle after valid

	modport scanner (
		output valid, tile, row, palette, flipX, posX,
		input  busy
	);

	modport fetcher (
		input  valid, tile, row, palette, flipX, posX,
		output busy
	);

endinterface

// File: verilog/spriteScanner.sv
// Sprite line scanner
// Walks all sprite records for the line being prepared, applies the
// vertical hit test and hands each hit sprite to the tile fetcher
`timescale 1ns/1ps

module spriteScanner #(
	parameter int spriteCount = 128
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            lineStart,
	input  spriteFormatPkg::lineT           lineY,
	input  spriteFormatPkg::attrByteT       scanData,
	input  logic                            scanGrant,
	output logic                            scanRead,
	output logic [$clog2(spriteCount)+1:0]  scanAddr,
	output logic                            scanBusy,
	spriteJobIf.scanner                     job
);

	localparam int indexBits = $clog2(spriteCount);

	typedef enum logic [2:0] {
		idle,
		readY,
		readAttr,
		readTileLo,
		readX,
		issue,
		waitFetcher
	} stateT;

	stateT                     state;
	stateT                     afterSprite; // Where to go once a sprite is done
	logic [indexBits-1:0]      index;       // Current sprite
	logic                      pending;     // Read in flight, wait for grant
	logic [1:0]                offset;      // Byte within the record
	spriteFormatPkg::lineT     curLine;     // Line latched at lineStart
	spriteFormatPkg::lineT     sum;
	spriteFormatPkg::lineT     ySum;
	spriteFormatPkg::attrByteT attr;
	logic                      lastSprite;

	// ------------------------------------------------------------------------
	// RAM read side
	// ------------------------------------------------------------------------
	always_comb begin
		case (state)
			readAttr:   offset = spriteFormatPkg::offsetAttr;
			readTileLo: offset = spriteFormatPkg::offsetTileLo;
			readX:      offset = spriteFormatPkg::offsetPosX;
			default:    offset = spriteFormatPkg::offsetPosY;
		endcase
	end

	assign scanAddr = {index, offset};
	assign scanRead = !pending && (state inside {readY, readAttr, readTileLo, readX});

	assign sum         = curLine + scanData; // Wraps modulo 256
	assign lastSprite  = (index == indexBits'(spriteCount - 1));
	assign afterSprite = lastSprite ? waitFetcher : readY;
	assign scanBusy    = (state != idle);

	// ------------------------------------------------------------------------
	// Scan FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= idle;
			index     <= '0;
			pending   <= 1'b0;
			job.valid <= 1'b0;
		end else begin
			job.valid <= 1'b0;     // Pulse only
			pending   <= scanRead; // Cleared next cycle, grant or not
			case (state)
				idle: begin
					if (lineStart) begin
						curLine <= lineY;
						index   <= '0;
						state   <= readY;
					end
				end
				readY: begin
					if (scanGrant) begin
						ySum <= sum;
						if (&sum[7:5]) begin
							state <= readAttr;
						end else begin
							state <= afterSprite; // Off this line
							index <= index + 1'b1;
						end
					end
				end
				readAttr: begin
					if (scanGrant) begin
						attr <= scanData;
						// Lower half needs the double-height bit
						if (ySum[4] || scanData[7]) begin
							state <= readTileLo;
						end else begin
							state <= afterSprite;
							index <= index + 1'b1;
						end
					end
				end
				readTileLo: begin
					if (scanGrant) begin
						if (attr[7]) begin
							job.tile <= {attr[2:0], scanData[7:1], ySum[4]}; // Upper/lower tile
						end else begin
							job.tile <= {attr[2:0], scanData};
						end
						job.row     <= ySum[3:0];
						job.palette <= attr[5:3];
						job.flipX   <= attr[6];
						state       <= readX;
					end
				end
				readX: begin
					if (scanGrant) begin
						job.posX <= scanData;
						state    <= issue;
					end
				end
				issue: begin
					if (!job.busy) begin
						job.valid <= 1'b1; // Fetcher latches the fields now
						state     <= afterSprite;
						index     <= index + 1'b1;
					end
				end
				waitFetcher: begin
					// Last job may still be in its valid cycle
					if (!job.busy && !job.valid) begin
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

// File: verilog/tileFetcher.sv
// Tile row fetcher
// Reads the four column words of one sprite row from the graphics ROM and
// writes the opaque pixels into the draw line buffer, one per cycle
`timescale 1ns/1ps

module tileFetcher (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     romRdy,
	input  busPkg::romWordT          romData,
	output logic                     romReq,
	output busPkg::romAddrT          romAddr,
	output logic                     drawWrite,
	output spriteFormatPkg::screenXT drawX,
	output spriteFormatPkg::pixelT   drawPixel,
	spriteJobIf.fetcher              job
);

	typedef enum logic [1:0] {
		idle,
		request,
		waitRom,
		drawPixels
	} stateT;

	stateT                     state;
	spriteFormatPkg::tileT     tile;
	spriteFormatPkg::rowT      row;
	spriteFormatPkg::paletteT  palette;
	logic                      flipX;
	spriteFormatPkg::screenXT  posX;
	spriteFormatPkg::columnT   column;    // Word being drawn
	logic [1:0]                pixelIdx;  // Pixel within the word
	busPkg::romWordT           word;      // Shifts left, current pixel on top
	spriteFormatPkg::colorT    color;
	logic [3:0]                spriteCol; // 0..15 across the sprite
	logic [3:0]                placeCol;  // After mirroring

	assign job.busy  = (state != idle);
	assign color     = word[15:12];
	assign spriteCol = {column, pixelIdx};
	assign placeCol  = flipX ? 4'(spriteFormatPkg::spriteWidth - 1) - spriteCol : spriteCol;

	// ------------------------------------------------------------------------
	// Fetch and draw FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= idle;
			romReq    <= 1'b0;
			drawWrite <= 1'b0;
		end else begin
			romReq    <= 1'b0;
			drawWrite <= 1'b0;
			case (state)
				idle: begin
					if (job.valid) begin
						tile     <= job.tile;
						row      <= job.row;
						palette  <= job.palette;
						flipX    <= job.flipX;
						posX     <= job.posX;
						column   <= '0;
						pixelIdx <= '0;
						state    <= request;
					end
				end
				request: begin
					romReq  <= 1'b1;
					romAddr <= {tile, column, row};
					state   <= waitRom; // romRdy may already come with the request
				end
				waitRom: begin
					if (romRdy) begin
						word  <= romData;
						state <= drawPixels;
					end
				end
				drawPixels: begin
					drawWrite <= (color != '0);           // Color 0 is see-through
					drawX     <= posX + {4'b0, placeCol}; // Wraps at 256
					drawPixel <= {palette, color};
					word      <= word << 4;
					pixelIdx  <= pixelIdx + 1'b1;
					if (pixelIdx == 2'(spriteFormatPkg::pixelsPerWord - 1)) begin
						if (column == 2'd3) begin
							state <= idle; // busy falls with the last write
						end else begin
							column <= column + 1'b1;
							state  <= request;
						end
					end
				end
				default: state <= idle;
			endcase
		end
	end

endmodule
